// File: hw/kitchen_pkg.sv
`default_nettype none

package kitchen_pkg;

    // Counter layout.
    localparam int NUM_SPOTS  = 2;
    localparam int NUM_ORDERS = 4;

    // Dish codes.
    localparam int DISH_W = 4;
    localparam logic [DISH_W-1:0] DISH_EMPTY = 4'd0;
    localparam logic [DISH_W-1:0] DISH_DONE  = 4'd4;   // Finished dish, fills an order.

    // Order countdowns in seconds.
    localparam int TIME_W = 5;
    localparam logic [TIME_W-1:0] ORDER_START_TIME = 5'd30;

    // Scoring.
    localparam int POINTS_W = 10;
    localparam logic [POINTS_W-1:0] SERVE_POINTS = 10'd20;
    localparam logic [POINTS_W-1:0] LATE_PENALTY = 10'd10;
    localparam logic [POINTS_W-1:0] BONUS_HI     = 10'd6;
    localparam logic [POINTS_W-1:0] BONUS_MID    = 10'd4;
    localparam logic [POINTS_W-1:0] BONUS_LO     = 10'd2;

    // Bonus thresholds, compared against the remaining countdown.
    localparam logic [TIME_W-1:0] BONUS_HI_T  = 5'd15;
    localparam logic [TIME_W-1:0] BONUS_MID_T = 5'd10;
    localparam logic [TIME_W-1:0] BONUS_LO_T  = 5'd5;

endpackage

`default_nettype wire

// File: hw/round_timer.sv
`default_nettype none

module round_timer #(
    parameter int one_sec    = 60,
    parameter int round_secs = 120
) (
    input  logic       vsync,
    input  logic       reset,
    input  logic       round_start,
    output logic       timer_go,
    output logic [7:0] seconds_left,
    output logic       round_over
);

    localparam int FRAME_W = $clog2(one_sec + 1);
    localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(one_sec - 1);
    localparam logic [7:0] ROUND_LEN = 8'(round_secs);

    logic [FRAME_W-1:0] frame_cnt;   // Frames into the current second.

    always_ff @(posedge vsync) begin
        if (reset) begin
            timer_go     <= 1'b0;
            round_over   <= 1'b0;
            seconds_left <= '0;
            frame_cnt    <= '0;
        end else if (!timer_go) begin
            // Idle or finished; a start level launches a fresh round.
            if (round_start) begin
                timer_go     <= 1'b1;
                round_over   <= 1'b0;
                seconds_left <= ROUND_LEN;
                frame_cnt    <= '0;
            end
        end else if (frame_cnt == FRAME_LAST) begin
            frame_cnt    <= '0;
            seconds_left <= seconds_left - 8'd1;
            if (seconds_left == 8'd1) begin   // Last second just ran out.
                timer_go   <= 1'b0;
                round_over <= 1'b1;
            end
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/serving_counter.sv
`default_nettype none

module serving_counter (
    input  logic                                                    vsync,
    input  logic                                                    reset,
    input  logic                                                    place_req,
    input  logic                                                    place_spot,
    input  logic [kitchen_pkg::DISH_W-1:0]                          place_dish,
    output logic                                                    place_ack,
    input  logic [kitchen_pkg::NUM_SPOTS-1:0]                       clear_space,
    output logic [kitchen_pkg::NUM_SPOTS-1:0][kitchen_pkg::DISH_W-1:0] check_spaces
);

    logic [kitchen_pkg::NUM_SPOTS-1:0][kitchen_pkg::DISH_W-1:0] dishes;
    logic                                                       spot_free;
    logic                                                       accept;

    // A spot with a pending clear still shows its old dish, so it is not free yet.
    assign spot_free = (dishes[place_spot] == kitchen_pkg::DISH_EMPTY) &&
                       !clear_space[place_spot];

    // Two-state handshake: place_ack low waits for a request, high waits for release.
    assign accept = !place_ack && place_req && spot_free;

    always_ff @(posedge vsync) begin
        if (reset) begin
            place_ack <= 1'b0;
        end else if (accept) begin
            place_ack <= 1'b1;
        end else if (place_ack && !place_req) begin
            place_ack <= 1'b0;   // Player let go of the request.
        end
    end

    // Spot storage. A clear wins over a write to the same spot.
    always_ff @(posedge vsync) begin
        if (reset) begin
            dishes <= {kitchen_pkg::NUM_SPOTS{kitchen_pkg::DISH_EMPTY}};
        end else begin
            for (int s = 0; s < kitchen_pkg::NUM_SPOTS; s++) begin
                if (clear_space[s]) begin
                    dishes[s] <= kitchen_pkg::DISH_EMPTY;
                end else if (accept && (32'(place_spot) == s)) begin
                    dishes[s] <= place_dish;
                end
            end
        end
    end

    assign check_spaces = dishes;

endmodule

`default_nettype wire

// File: hw/orders_and_points.sv
`default_nettype none

module orders_and_points #(
    parameter int one_sec    = 60,
    parameter int order_time = 1200
) (
    input  logic                                                     vsync,
    input  logic                                                     reset,
    input  logic [kitchen_pkg::NUM_SPOTS-1:0][kitchen_pkg::DISH_W-1:0] check_spaces,
    input  logic                                                     timer_go,
    output logic [kitchen_pkg::NUM_SPOTS-1:0]                        clear_space,
    output logic [kitchen_pkg::POINTS_W-1:0]                         point_total,
    output logic [kitchen_pkg::NUM_ORDERS-1:0]                       orders,
    output logic [kitchen_pkg::NUM_ORDERS-1:0][kitchen_pkg::TIME_W-1:0] order_times
);

    localparam int SPOT_W = $clog2(kitchen_pkg::NUM_SPOTS);
    localparam int SEC_W  = $clog2(one_sec + 1);
    localparam int ARR_W  = $clog2(order_time + 1);
    localparam logic [SEC_W-1:0] SEC_MAX = SEC_W'(one_sec);
    localparam logic [ARR_W-1:0] ARR_MAX = ARR_W'(order_time);

    logic [SEC_W-1:0]  second_cnt;
    logic [ARR_W-1:0]  arrival_cnt;
    logic              serve_hit;
    logic [SPOT_W-1:0] serve_idx;
    logic              expired;

    // Points for a serve, bigger the more time the order had left.
    function automatic logic [kitchen_pkg::POINTS_W-1:0] serve_award(
        input logic [kitchen_pkg::TIME_W-1:0] t
    );
        if (t > kitchen_pkg::BONUS_HI_T) begin
            return kitchen_pkg::SERVE_POINTS + kitchen_pkg::BONUS_HI;
        end else if (t > kitchen_pkg::BONUS_MID_T) begin
            return kitchen_pkg::SERVE_POINTS + kitchen_pkg::BONUS_MID;
        end else if (t > kitchen_pkg::BONUS_LO_T) begin
            return kitchen_pkg::SERVE_POINTS + kitchen_pkg::BONUS_LO;
        end
        return kitchen_pkg::SERVE_POINTS;
    endfunction

    // Lowest spot holding a finished dish. A spot already being cleared is skipped,
    // its dish is still visible for that one cycle.
    always_comb begin
        serve_hit = 1'b0;
        serve_idx = '0;
        for (int s = kitchen_pkg::NUM_SPOTS - 1; s >= 0; s--) begin
            if ((check_spaces[s] == kitchen_pkg::DISH_DONE) && !clear_space[s]) begin
                serve_hit = 1'b1;
                serve_idx = SPOT_W'(s);
            end
        end
    end

    assign expired = (order_times[0] == '0) || (order_times[1] == '0);

    always_ff @(posedge vsync) begin
        if (reset) begin
            clear_space <= '0;
            point_total <= '0;
            orders      <= '0;
            order_times <= {kitchen_pkg::NUM_ORDERS{kitchen_pkg::ORDER_START_TIME}};
            second_cnt  <= '0;
            arrival_cnt <= '0;
        end else begin
            clear_space <= '0;   // Pulse only.
            if (timer_go) begin
                // Both counters run until their event is taken.
                if (second_cnt < SEC_MAX) begin
                    second_cnt <= second_cnt + 1'b1;
                end
                if (arrival_cnt < ARR_MAX) begin
                    arrival_cnt <= arrival_cnt + 1'b1;
                end

                if (serve_hit) begin
                    point_total <= point_total + serve_award(order_times[serve_idx]);
                    orders      <= {1'b0, orders[kitchen_pkg::NUM_ORDERS-1:1]};
                    order_times <= {kitchen_pkg::ORDER_START_TIME,
                                    order_times[kitchen_pkg::NUM_ORDERS-1:1]};
                    clear_space[serve_idx] <= 1'b1;
                end else if (expired) begin
                    if (point_total > 10'd9) begin
                        point_total <= point_total - kitchen_pkg::LATE_PENALTY;
                    end
                    orders      <= {1'b0, orders[kitchen_pkg::NUM_ORDERS-1:1]};
                    order_times <= {kitchen_pkg::ORDER_START_TIME,
                                    order_times[kitchen_pkg::NUM_ORDERS-1:1]};
                end else if (orders == '0) begin
                    orders      <= {{(kitchen_pkg::NUM_ORDERS-1){1'b0}}, 1'b1};
                    arrival_cnt <= ARR_W'(1);
                end else if (arrival_cnt >= ARR_MAX) begin
                    // Full queue stays full.
                    orders      <= {orders[kitchen_pkg::NUM_ORDERS-2:0], 1'b1};
                    arrival_cnt <= ARR_W'(1);
                end else if (second_cnt >= SEC_MAX) begin
                    second_cnt <= SEC_W'(1);
                    for (int i = 0; i < kitchen_pkg::NUM_ORDERS; i++) begin
                        if (orders[i] && (order_times[i] != '0)) begin
                            order_times[i] <= order_times[i] - 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/kitchen_game.sv
`default_nettype none

module kitchen_game #(
    parameter int one_sec    = 60,
    parameter int order_time = 1200,
    parameter int round_secs = 120
) (
    input  logic                                                     vsync,
    input  logic                                                     reset,
    input  logic                                                     round_start,
    input  logic                                                     place_req,
    input  logic                                                     place_spot,
    input  logic [kitchen_pkg::DISH_W-1:0]                           place_dish,
    output logic                                                     place_ack,
    output logic [kitchen_pkg::POINTS_W-1:0]                         point_total,
    output logic [kitchen_pkg::NUM_ORDERS-1:0]                       orders,
    output logic [kitchen_pkg::NUM_ORDERS-1:0][kitchen_pkg::TIME_W-1:0] order_times,
    output logic [7:0]                                               seconds_left,
    output logic                                                     round_over
);

    logic                                                       timer_go;
    logic [kitchen_pkg::NUM_SPOTS-1:0][kitchen_pkg::DISH_W-1:0] check_spaces;
    logic [kitchen_pkg::NUM_SPOTS-1:0]                          clear_space;

    round_timer #(
        .one_sec    (one_sec),
        .round_secs (round_secs)
    ) u_round_timer (
        .vsync        (vsync),
        .reset        (reset),
        .round_start  (round_start),
        .timer_go     (timer_go),
        .seconds_left (seconds_left),
        .round_over   (round_over)
    );

    serving_counter u_serving_counter (
        .vsync        (vsync),
        .reset        (reset),
        .place_req    (place_req),
        .place_spot   (place_spot),
        .place_dish   (place_dish),
        .place_ack    (place_ack),
        .clear_space  (clear_space),
        .check_spaces (check_spaces)
    );

    orders_and_points #(
        .one_sec    (one_sec),
        .order_time (order_time)
    ) u_orders_and_points (
        .vsync        (vsync),
        .reset        (reset),
        .check_spaces (check_spaces),
        .timer_go     (timer_go),
        .clear_space  (clear_space),
        .point_total  (point_total),
        .orders       (orders),
        .order_times  (order_times)
    );

endmodule

`default_nettype wire

// File: dv/kitchen_game_assertions.sv
`default_nettype none

module kitchen_game_assertions (
    input logic                              vsync,
    input logic                              reset,
    input logic                              place_req,
    input logic                              place_ack,
    input logic [kitchen_pkg::NUM_SPOTS-1:0] clear_space
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;   // Read by the testbench at the end of the run.

    ack_needs_req: assert property (@(posedge vsync) disable iff (reset)
        $rose(place_ack) |-> $past(place_req))
    else begin
        failures++;
        $error("place_ack rose without place_req");
    end

    // Ack is released only after the request goes away.
    ack_holds: assert property (@(posedge vsync) disable iff (reset)
        place_ack && place_req |=> place_ack)
    else begin
        failures++;
        $error("place_ack fell while place_req was still high");
    end

    clear0_pulse: assert property (@(posedge vsync) disable iff (reset)
        clear_space[0] |=> !clear_space[0])
    else begin
        failures++;
        $error("clear_space[0] was high for more than one cycle");
    end

    clear1_pulse: assert property (@(posedge vsync) disable iff (reset)
        clear_space[1] |=> !clear_space[1])
    else begin
        failures++;
        $error("clear_space[1] was high for more than one cycle");
    end

endmodule

bind serving_counter kitchen_game_assertions u_assertions (
    .vsync       (vsync),
    .reset       (reset),
    .place_req   (place_req),
    .place_ack   (place_ack),
    .clear_space (clear_space)
);

`default_nettype wire

// File: dv/kitchen_game_tb.sv
`default_nettype none

module kitchen_game_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 400;   // Cycles allowed for any single wait.
    localparam int BP_WINDOW  = 24;

    logic                                                        vsync = 1'b0;
    logic                                                        reset;
    logic                                                        round_start;
    logic                                                        place_req;
    logic                                                        place_spot;
    logic [kitchen_pkg::DISH_W-1:0]                              place_dish;
    logic                                                        place_ack;
    logic [kitchen_pkg::POINTS_W-1:0]                            point_total;
    logic [kitchen_pkg::NUM_ORDERS-1:0]                          orders;
    logic [kitchen_pkg::NUM_ORDERS-1:0][kitchen_pkg::TIME_W-1:0] order_times;
    logic [7:0]                                                  seconds_left;
    logic                                                        round_over;

    integer                           seed = 32'h1b15;
    int                               errors = 0;
    int                               checks = 0;
    logic [kitchen_pkg::POINTS_W-1:0] score;   // Score expected from the scoring rules.

    kitchen_game #(
        .one_sec    (4),
        .order_time (40),
        .round_secs (60)
    ) dut (
        .vsync        (vsync),
        .reset        (reset),
        .round_start  (round_start),
        .place_req    (place_req),
        .place_spot   (place_spot),
        .place_dish   (place_dish),
        .place_ack    (place_ack),
        .point_total  (point_total),
        .orders       (orders),
        .order_times  (order_times),
        .seconds_left (seconds_left),
        .round_over   (round_over)
    );

    always #10 vsync = ~vsync;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    // Any code except empty and done.
    task automatic random_dish(output logic [kitchen_pkg::DISH_W-1:0] dish);
        logic [31:0] r;
        do begin
            r = $random(seed);
            dish = r[kitchen_pkg::DISH_W-1:0];
        end while (dish == kitchen_pkg::DISH_DONE || dish == kitchen_pkg::DISH_EMPTY);
    endtask

    task automatic place_dish_at(input logic spot, input logic [kitchen_pkg::DISH_W-1:0] dish);
        int n;
        @(negedge vsync);
        place_spot = spot;
        place_dish = dish;
        place_req  = 1'b1;
        n = 0;
        while (!place_ack && n < WAIT_LIMIT) begin
            @(negedge vsync);
            n++;
        end
        confirm(place_ack, "place_ack did not rise for a placement");
        place_req = 1'b0;
        n = 0;
        while (place_ack && n < WAIT_LIMIT) begin
            @(negedge vsync);
            n++;
        end
        confirm(!place_ack, "place_ack did not fall after place_req dropped");
    endtask

    task automatic reset_values();
        compare_value("orders", 32'(orders), 32'd0);
        compare_value("point_total", 32'(point_total), 32'd0);
        for (int i = 0; i < kitchen_pkg::NUM_ORDERS; i++) begin
            compare_value("order_times", 32'(order_times[i]),
                          32'(kitchen_pkg::ORDER_START_TIME));
        end
        compare_value("place_ack", 32'(place_ack), 32'd0);
        compare_value("round_over", 32'(round_over), 32'd0);
    endtask

    task automatic first_order();
        int n;
        @(negedge vsync);
        round_start = 1'b1;
        n = 0;
        while (orders == '0 && n < WAIT_LIMIT) begin
            @(negedge vsync);
            n++;
        end
        confirm(orders != '0, "no order opened after round_start");
        compare_value("orders", 32'(orders), 32'd1);
        round_start = 1'b0;   // A held level would restart the round at its end.
    endtask

    // The second placement only gets an ack once the served spot reads empty.
    task automatic fast_serve();
        logic [kitchen_pkg::NUM_ORDERS-1:0] orders_before;
        for (int k = 0; k < 2; k++) begin
            orders_before = orders;
            confirm(order_times[0] > kitchen_pkg::BONUS_HI_T,
                    "order countdown already below the top bonus threshold");
            place_dish_at(1'b0, kitchen_pkg::DISH_DONE);
            score = score + kitchen_pkg::SERVE_POINTS + kitchen_pkg::BONUS_HI;
            compare_value("point_total", 32'(point_total), 32'(score));
            if (k == 0) begin
                compare_value("orders", 32'(orders), 32'(orders_before >> 1));
            end
        end
    endtask

    task automatic back_pressure();
        logic [kitchen_pkg::DISH_W-1:0] dish;
        int acks;
        random_dish(dish);
        place_dish_at(1'b1, dish);
        random_dish(dish);
        @(negedge vsync);
        place_spot = 1'b1;
        place_dish = dish;
        place_req  = 1'b1;
        acks = 0;
        repeat (BP_WINDOW) begin
            @(negedge vsync);
            if (place_ack) begin
                acks++;
            end
        end
        place_req = 1'b0;
        confirm(acks == 0, "place_ack rose for a placement on a full spot");
    endtask

    task automatic order_expiry();
        logic [kitchen_pkg::POINTS_W-1:0] expected;
        int n;
        n = 0;
        while (order_times[0] != '0 && order_times[1] != '0 && n < WAIT_LIMIT) begin
            @(negedge vsync);
            n++;
        end
        confirm(order_times[0] == '0 || order_times[1] == '0,
                "no order countdown reached zero");
        compare_value("point_total", 32'(point_total), 32'(score));
        expected = (score > 10'd9) ? score - kitchen_pkg::LATE_PENALTY : score;
        @(negedge vsync);   // Penalty lands on the next edge.
        compare_value("point_total", 32'(point_total), 32'(expected));
        score = expected;
    endtask

    task automatic round_end();
        logic [kitchen_pkg::NUM_ORDERS-1:0] held_orders;
        int n;
        n = 0;
        while (!round_over && n < WAIT_LIMIT) begin
            // Orders keep expiring until the round is over.
            if (order_times[0] == '0 || order_times[1] == '0) begin
                score = (score > 10'd9) ? score - kitchen_pkg::LATE_PENALTY : score;
            end
            @(negedge vsync);
            n++;
        end
        confirm(round_over, "round_over did not rise at the end of the round");
        compare_value("seconds_left", 32'(seconds_left), 32'd0);
        compare_value("point_total", 32'(point_total), 32'(score));
        held_orders = orders;
        place_dish_at(1'b0, kitchen_pkg::DISH_DONE);
        repeat (8) @(negedge vsync);
        compare_value("point_total", 32'(point_total), 32'(score));
        compare_value("orders", 32'(orders), 32'(held_orders));
    endtask

    initial begin
        reset       = 1'b1;
        round_start = 1'b0;
        place_req   = 1'b0;
        place_spot  = 1'b0;
        place_dish  = kitchen_pkg::DISH_EMPTY;
        score       = '0;
        repeat (16) @(negedge vsync);
        reset = 1'b0;

        reset_values();
        first_order();
        fast_serve();
        back_pressure();
        order_expiry();
        round_end();

        errors = errors + dut.u_serving_counter.u_assertions.failures;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: kitchen_game.f
hw/kitchen_pkg.sv
hw/round_timer.sv
hw/serving_counter.sv
hw/orders_and_points.sv
hw/kitchen_game.sv
dv/kitchen_game_assertions.sv
dv/kitchen_game_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = kitchen_game_tb
FILELIST = kitchen_game.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
